// ==== source/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Player count and joystick word layout
    localparam int num_players = 4;
    localparam int joy_w       = 10;

    // OSD status word
    localparam int status_w        = 64;
    localparam int st_rotate_bit   = 2;
    localparam int st_flip_bit     = 3;
    localparam int st_autofire_bit = 4;
    localparam int st_pause_bit    = 5;

    // Frame based timing
    localparam int autofire_frames = 2;
    localparam int coin_frames     = 2;
    localparam int af_cnt_w        = $clog2(autofire_frames + 1);
    localparam int coin_cnt_w      = $clog2(coin_frames + 1);

    // Game side inputs are active low
    localparam bit game_active_low = 1'b1;

    // Bits 3..0 are up, down, left, right; buttons sit above them
    typedef struct packed {
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_t;

    typedef struct packed {
        joy_t joy;
        logic start;
        logic coin;
    } player_in_t;

    typedef struct packed {
        joy_t joy;
        logic start;
        logic coin;
    } player_out_t;

    typedef struct packed {
        logic rotate;
        logic flip;
        logic autofire;
        logic pause;
    } board_cfg_t;

    typedef enum logic [1:0] {
        af_idle,
        af_fire_on,
        af_fire_off
    } af_state_e;

endpackage

`default_nettype wire

// ==== source/board_dip.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_dip (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  logic [board_pkg::status_w-1:0] status,
    input  logic                          osd_shown,
    output board_pkg::board_cfg_t         cfg
);
    import board_pkg::*;

    // Settings picked out of the OSD status word
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            cfg <= '0;
        end else begin
            cfg.rotate   <= status[st_rotate_bit];
            cfg.flip     <= status[st_flip_bit];
            cfg.autofire <= status[st_autofire_bit];
            // Game halts while the menu is open too
            cfg.pause    <= status[st_pause_bit] | osd_shown;
        end
    end

    // Status word from the OSD must be fully driven once out of reset
    a_cfg_known: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$isunknown(cfg)
    );

endmodule

`default_nettype wire

// ==== source/input_fanout.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_fanout (
    input  logic                                                clk_sys,
    input  logic                                                rst_n,
    input  logic [board_pkg::num_players-1:0][board_pkg::joy_w-1:0] board_joystick,
    input  logic [board_pkg::num_players-1:0]                   board_start,
    input  logic [board_pkg::num_players-1:0]                   board_coin,
    input  logic                                                vs,
    input  board_pkg::board_cfg_t                               dip_cfg,
    output board_pkg::player_in_t [board_pkg::num_players-1:0]  players,
    output logic                                                frame,
    output board_pkg::board_cfg_t                               cfg
);
    import board_pkg::*;

    logic [num_players-1:0][joy_w-1:0] joy_s1;
    logic [num_players-1:0][joy_w-1:0] joy_s2;
    logic [num_players-1:0]            start_s1;
    logic [num_players-1:0]            start_s2;
    logic [num_players-1:0]            coin_s1;
    logic [num_players-1:0]            coin_s2;
    // Two sync stages plus one for edge detection
    logic [2:0]                        vs_sync;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            joy_s1   <= '0;
            joy_s2   <= '0;
            start_s1 <= '0;
            start_s2 <= '0;
            coin_s1  <= '0;
            coin_s2  <= '0;
            vs_sync  <= '0;
        end else begin
            joy_s1   <= board_joystick;
            joy_s2   <= joy_s1;
            start_s1 <= board_start;
            start_s2 <= start_s1;
            coin_s1  <= board_coin;
            coin_s2  <= coin_s1;
            vs_sync  <= {vs_sync[1:0], vs};
        end
    end

    // Output stage, aligned with the frame strobe
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            players <= '0;
            frame   <= 1'b0;
            cfg     <= '0;
        end else begin
            for (int i = 0; i < num_players; i++) begin
                players[i] <= {joy_s2[i], start_s2[i], coin_s2[i]};
            end
            frame <= vs_sync[1] & ~vs_sync[2];
            cfg   <= dip_cfg;
        end
    end

    a_frame_single: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        frame |=> !frame
    );

endmodule

`default_nettype wire

// ==== source/player_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_channel (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  board_pkg::player_in_t   player,
    input  logic                    frame,
    input  board_pkg::board_cfg_t   cfg,
    output board_pkg::player_out_t  player_out
);
    import board_pkg::*;

    joy_t                joy_rot;
    joy_t                joy_map;
    af_state_e           af_state;
    logic [af_cnt_w-1:0] af_cnt;
    logic                af_last;
    logic                btn0_held;

    assign btn0_held = player.joy.buttons[0];
    assign af_last   = (af_cnt == af_cnt_w'(autofire_frames - 1));

    always_comb begin
        joy_rot = player.joy;
        // Vertical cabinet, directions turn clockwise
        if (cfg.rotate) begin
            joy_rot.up    = player.joy.right;
            joy_rot.right = player.joy.down;
            joy_rot.down  = player.joy.left;
            joy_rot.left  = player.joy.up;
        end
        joy_map = joy_rot;
        if (cfg.flip) begin
            joy_map.up    = joy_rot.down;
            joy_map.down  = joy_rot.up;
            joy_map.left  = joy_rot.right;
            joy_map.right = joy_rot.left;
        end
        case (af_state)
            af_fire_on:  joy_map.buttons[0] = 1'b1;
            af_fire_off: joy_map.buttons[0] = 1'b0;
            default:     joy_map.buttons[0] = btn0_held;
        endcase
    end

    // Autofire FSM, each phase lasts autofire_frames frames
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            af_state <= af_idle;
            af_cnt   <= '0;
        end else if (!cfg.autofire || !btn0_held) begin
            af_state <= af_idle;
            af_cnt   <= '0;
        end else begin
            case (af_state)
                af_idle: begin
                    af_state <= af_fire_on;
                    af_cnt   <= '0;
                end
                af_fire_on, af_fire_off: begin
                    if (frame) begin
                        if (af_last) begin
                            af_cnt <= '0;
                            if (af_state == af_fire_on) begin
                                af_state <= af_fire_off;
                            end else begin
                                af_state <= af_fire_on;
                            end
                        end else begin
                            af_cnt <= af_cnt + 1'b1;
                        end
                    end
                end
                default: af_state <= af_idle;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            player_out <= '0;
        end else begin
            player_out <= {joy_map, player.start, player.coin};
        end
    end

    a_af_idle_when_off: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (!cfg.autofire && $past(!cfg.autofire)) |-> (af_state == af_idle)
    );

endmodule

`default_nettype wire

// ==== source/input_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_merge (
    input  logic                                                 clk_sys,
    input  logic                                                 rst_n,
    input  board_pkg::player_out_t [board_pkg::num_players-1:0]  players,
    input  logic                                                 frame,
    input  board_pkg::board_cfg_t                                cfg,
    output logic [board_pkg::num_players-1:0][board_pkg::joy_w-1:0] game_joystick,
    output logic [board_pkg::num_players-1:0]                    game_start,
    output logic [board_pkg::num_players-1:0]                    game_coin
);
    import board_pkg::*;

    logic [num_players-1:0] coin_active;

    for (genvar i = 0; i < num_players; i++) begin : g_coin
        logic                  coin_prev;
        logic [coin_cnt_w-1:0] coin_cnt;

        // Short presses are held for coin_frames frames
        always_ff @(posedge clk_sys) begin
            if (!rst_n) begin
                coin_prev <= 1'b0;
                coin_cnt  <= '0;
            end else begin
                coin_prev <= players[i].coin;
                if (players[i].coin && !coin_prev) begin
                    coin_cnt <= coin_cnt_w'(coin_frames);
                end else if (frame && coin_cnt != '0) begin
                    coin_cnt <= coin_cnt - 1'b1;
                end
            end
        end

        assign coin_active[i] = players[i].coin | (coin_cnt != '0);

        a_coin_release: assert property (
            @(posedge clk_sys) disable iff (!rst_n)
            ($fell(players[i].coin) ##0
                (!players[i].coin throughout frame [-> coin_frames + 1]))
            |=> (game_coin[i] == game_active_low)
        );
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            game_joystick <= {num_players{ {joy_w{game_active_low}} }};
            game_start    <= {num_players{game_active_low}};
            game_coin     <= {num_players{game_active_low}};
        end else begin
            for (int i = 0; i < num_players; i++) begin
                // Pause lets go of sticks and starts, coins keep counting
                if (cfg.pause) begin
                    game_joystick[i] <= {joy_w{game_active_low}};
                end else begin
                    game_joystick[i] <= players[i].joy ^ {joy_w{game_active_low}};
                end
                game_start[i] <= (players[i].start & ~cfg.pause) ^ game_active_low;
            end
            game_coin <= coin_active ^ {num_players{game_active_low}};
        end
    end

endmodule

`default_nettype wire

// ==== source/board_inputs.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_inputs (
    input  logic                                                clk_sys,
    input  logic                                                rst_n,
    input  logic [board_pkg::status_w-1:0]                      status,
    input  logic                                                osd_shown,
    input  logic                                                vs,
    input  logic [board_pkg::num_players-1:0][board_pkg::joy_w-1:0] board_joystick,
    input  logic [board_pkg::num_players-1:0]                   board_start,
    input  logic [board_pkg::num_players-1:0]                   board_coin,
    output logic [board_pkg::num_players-1:0][board_pkg::joy_w-1:0] game_joystick,
    output logic [board_pkg::num_players-1:0]                   game_start,
    output logic [board_pkg::num_players-1:0]                   game_coin
);
    import board_pkg::*;

    board_cfg_t                    dip_cfg;
    board_cfg_t                    chan_cfg;
    player_in_t  [num_players-1:0] players_in;
    player_out_t [num_players-1:0] players_out;
    logic                          frame;

    board_dip u_dip (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .status    (status),
        .osd_shown (osd_shown),
        .cfg       (dip_cfg)
    );

    input_fanout u_fanout (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .board_joystick (board_joystick),
        .board_start    (board_start),
        .board_coin     (board_coin),
        .vs             (vs),
        .dip_cfg        (dip_cfg),
        .players        (players_in),
        .frame          (frame),
        .cfg            (chan_cfg)
    );

    // One channel per player
    for (genvar i = 0; i < num_players; i++) begin : g_player
        player_channel u_channel (
            .clk_sys    (clk_sys),
            .rst_n      (rst_n),
            .player     (players_in[i]),
            .frame      (frame),
            .cfg        (chan_cfg),
            .player_out (players_out[i])
        );
    end

    input_merge u_merge (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .players       (players_out),
        .frame         (frame),
        .cfg           (dip_cfg),
        .game_joystick (game_joystick),
        .game_start    (game_start),
        .game_coin     (game_coin)
    );

endmodule

`default_nettype wire

// ==== include/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Direction bits in a joystick word, button 0 right above them
localparam int dir_right = 0;
localparam int dir_left  = 1;
localparam int dir_down  = 2;
localparam int dir_up    = 3;
localparam int btn0_bit  = 4;

// Returns 5 ns after the n-th rising edge, where inputs change
task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #5;
endtask

task automatic pulse_vs();
    vs = 1'b1;
    wait_cycles(4);
    vs = 1'b0;
    wait_cycles(4);
endtask

// Vertical cabinet turns the stick a quarter clockwise
function automatic int turn_cw(input int dir);
    case (dir)
        dir_right: return dir_up;
        dir_down:  return dir_right;
        dir_left:  return dir_down;
        default:   return dir_left;
    endcase
endfunction

function automatic int mirror_dir(input int dir);
    case (dir)
        dir_right: return dir_left;
        dir_left:  return dir_right;
        dir_down:  return dir_up;
        default:   return dir_down;
    endcase
endfunction

// Expected values are pressed bits, the game side reads them inverted
task automatic check_outputs(
    input logic [num_players-1:0][joy_w-1:0] pressed_joy,
    input logic [num_players-1:0]            pressed_start,
    input logic [num_players-1:0]            pressed_coin,
    input string                             what
);
    checks++;
    for (int i = 0; i < num_players; i++) begin
        if (game_joystick[i] !== ~pressed_joy[i]) begin
            errors++;
            $display("mismatch at %0t: %s, player %0d joystick %h, expected %h",
                     $time, what, i, game_joystick[i], ~pressed_joy[i]);
        end
        if (game_start[i] !== ~pressed_start[i]) begin
            errors++;
            $display("mismatch at %0t: %s, player %0d start %b, expected %b",
                     $time, what, i, game_start[i], ~pressed_start[i]);
        end
        if (game_coin[i] !== ~pressed_coin[i]) begin
            errors++;
            $display("mismatch at %0t: %s, player %0d coin %b, expected %b",
                     $time, what, i, game_coin[i], ~pressed_coin[i]);
        end
    end
endtask

task automatic reset_released();
    wait_cycles(8);
    check_outputs('0, '0, '0, "released after reset");
endtask

task automatic random_passthrough();
    logic [num_players-1:0][joy_w-1:0] joy;
    logic [num_players-1:0]            start;
    status = '0;
    for (int n = 0; n < 8; n++) begin
        for (int i = 0; i < num_players; i++) begin
            joy[i] = joy_w'($urandom);
        end
        start          = num_players'($urandom);
        board_joystick = joy;
        board_start    = start;
        wait_cycles(8);
        check_outputs(joy, start, '0, "random passthrough");
    end
    board_joystick = '0;
    board_start    = '0;
    wait_cycles(8);
endtask

task automatic rotated_directions();
    logic [num_players-1:0][joy_w-1:0] expected;
    int                                out_dir;
    string                             what;
    for (int mode = 0; mode < 2; mode++) begin
        status                = '0;
        status[st_rotate_bit] = 1'b1;
        status[st_flip_bit]   = (mode == 1);
        for (int dir = 0; dir < 4; dir++) begin
            out_dir = turn_cw(dir);
            what    = "rotate";
            // Flip is applied after the rotation
            if (mode == 1) begin
                out_dir = mirror_dir(out_dir);
                what    = "rotate and flip";
            end
            for (int i = 0; i < num_players; i++) begin
                board_joystick[i]          = '0;
                board_joystick[i][dir]     = 1'b1;
                expected[i]                = '0;
                expected[i][out_dir]       = 1'b1;
            end
            wait_cycles(8);
            check_outputs(expected, '0, '0, what);
        end
    end
    status         = '0;
    board_joystick = '0;
    wait_cycles(8);
endtask

task automatic autofire_cadence();
    logic [num_players-1:0][joy_w-1:0] btn_held;
    logic [num_players-1:0][joy_w-1:0] expected;
    for (int i = 0; i < num_players; i++) begin
        btn_held[i]           = '0;
        btn_held[i][btn0_bit] = 1'b1;
    end
    status                  = '0;
    status[st_autofire_bit] = 1'b1;
    wait_cycles(8);
    board_joystick = btn_held;
    // k counts frames since the press, on and off phases alternate
    for (int k = 0; k < 4 * autofire_frames; k++) begin
        wait_cycles(8);
        expected = ((k / autofire_frames) % 2 == 0) ? btn_held : '0;
        check_outputs(expected, '0, '0, "autofire cadence");
        pulse_vs();
    end
    board_joystick = '0;
    status         = '0;
    wait_cycles(8);
    board_joystick = btn_held;
    for (int k = 0; k < 4; k++) begin
        wait_cycles(8);
        check_outputs(btn_held, '0, '0, "button 0 without autofire");
        pulse_vs();
    end
    board_joystick = '0;
    wait_cycles(8);
endtask

task automatic coin_stretch();
    board_coin = '1;
    wait_cycles(1);
    board_coin = '0;
    wait_cycles(8);
    check_outputs('0, '0, '1, "coin after a short press");
    pulse_vs();
    wait_cycles(8);
    check_outputs('0, '0, '1, "coin after one frame");
    pulse_vs();
    wait_cycles(8);
    check_outputs('0, '0, '0, "coin after two frames");
endtask

task automatic pause_release();
    logic [num_players-1:0][joy_w-1:0] joy;
    for (int i = 0; i < num_players; i++) begin
        joy[i] = joy_w'($urandom) | joy_w'(1);
    end
    board_joystick = joy;
    board_start    = '1;
    wait_cycles(8);
    check_outputs(joy, '1, '0, "held before pause");
    // First the status pause bit, then the OSD being shown
    for (int src = 0; src < 2; src++) begin
        if (src == 0) begin
            status[st_pause_bit] = 1'b1;
        end else begin
            osd_shown = 1'b1;
        end
        wait_cycles(8);
        check_outputs('0, '0, '0, "held during pause");
        status    = '0;
        osd_shown = 1'b0;
        wait_cycles(8);
        check_outputs(joy, '1, '0, "restored after pause");
    end
    board_joystick = '0;
    board_start    = '0;
    wait_cycles(8);
endtask

`endif

// ==== tests/tb_board_inputs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_inputs;
    import board_pkg::*;

    localparam int clk_period    = 40;
    // Roughly the sum of all test tasks, plus slack for the watchdog
    localparam int test_cycles   = 500;
    localparam int margin_cycles = 200;

    logic                              clk_sys;
    logic                              rst_n;
    logic [status_w-1:0]               status;
    logic                              osd_shown;
    logic                              vs;
    logic [num_players-1:0][joy_w-1:0] board_joystick;
    logic [num_players-1:0]            board_start;
    logic [num_players-1:0]            board_coin;
    logic [num_players-1:0][joy_w-1:0] game_joystick;
    logic [num_players-1:0]            game_start;
    logic [num_players-1:0]            game_coin;
    int                                errors;
    int                                checks;
    int unsigned                       seed_val;

    board_inputs dut (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .status         (status),
        .osd_shown      (osd_shown),
        .vs             (vs),
        .board_joystick (board_joystick),
        .board_start    (board_start),
        .board_coin     (board_coin),
        .game_joystick  (game_joystick),
        .game_start     (game_start),
        .game_coin      (game_coin)
    );

    always #(clk_period / 2) clk_sys = ~clk_sys;

    `include "tb_tasks.svh"

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("timeout: test sequence still running after %0d cycles",
                 test_cycles + margin_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errors         = 0;
        checks         = 0;
        clk_sys        = 1'b0;
        rst_n          = 1'b0;
        status         = '0;
        osd_shown      = 1'b0;
        vs             = 1'b0;
        board_joystick = '0;
        board_start    = '0;
        board_coin     = '0;
        seed_val       = $urandom(32'hff79_50d2);
        // Hold reset for 8 clocks, release just after an edge
        repeat (8) @(posedge clk_sys);
        #5;
        rst_n = 1'b1;

        reset_released();
        random_passthrough();
        rotated_directions();
        autofire_cadence();
        coin_stretch();
        pause_release();

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
source/board_pkg.sv
source/board_dip.sv
source/input_fanout.sv
source/player_channel.sv
source/input_merge.sv
source/board_inputs.sv
tests/tb_board_inputs.sv

// ==== Bender.yml ====
package:
  name: board_inputs

sources:
  - source/board_pkg.sv
  - source/board_dip.sv
  - source/input_fanout.sv
  - source/player_channel.sv
  - source/input_merge.sv
  - source/board_inputs.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_board_inputs.sv
